// File: Makefile
# Verilator simulation of the mask unit
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_masku -f masku.f
	./obj_dir/Vtb_masku | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/masku.sv
// Mask unit top level, runs bitwise mask instructions from the sequencer over four lanes
`timescale 1ns/1ps

module masku (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  // Sequencer
  input  masku_pkg::masku_req_t                               req_i,
  input  logic                                                req_valid_i,
  output logic                                                req_ready_o,
  // Operands from the lanes, A and M together
  input  masku_pkg::masku_operand_t [masku_pkg::NR_LANES-1:0] operand_i,
  input  logic                      [masku_pkg::NR_LANES-1:0] operand_valid_i,
  output logic                      [masku_pkg::NR_LANES-1:0] operand_ready_o,
  // Write-back to the lanes
  output logic                      [masku_pkg::NR_LANES-1:0] result_req_o,
  output masku_pkg::masku_result_t  [masku_pkg::NR_LANES-1:0] result_o,
  input  logic                      [masku_pkg::NR_LANES-1:0] result_gnt_i,
  // Completion
  output logic                      [masku_pkg::NR_VINSN-1:0] vinsn_done_o
);

  import masku_pkg::*;

  masku_req_t                   cur_req;
  logic                         load;
  logic                         issuing;
  logic                         issue_last;
  logic                         commit_zero;
  logic [1:0]                   beat_idx;
  logic [5:0]                   beat_bytes;
  masku_result_t [NR_LANES-1:0] alu_result;
  logic                         queue_full;
  logic                         pop;
  logic                         beat_fire;

  // A beat moves only with all lanes present and room in the queue
  assign beat_fire       = issuing && (&operand_valid_i) && !queue_full;
  assign operand_ready_o = {NR_LANES{beat_fire}};

  masku_ctrl_fsm i_ctrl_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .issue_last_i  (issue_last),
    .commit_zero_i (commit_zero),
    .beat_fire_i   (beat_fire),
    .cur_req_o     (cur_req),
    .load_o        (load),
    .issuing_o     (issuing),
    .vinsn_done_o  (vinsn_done_o)
  );

  // Issue side counts beats, commit side counts pops
  masku_elem_counter i_elem_counter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .load_i        (load),
    .vl_i          (req_i.vl),
    .beat_fire_i   (beat_fire),
    .pop_i         (pop),
    .issue_last_o  (issue_last),
    .commit_zero_o (commit_zero),
    .beat_idx_o    (beat_idx),
    .beat_bytes_o  (beat_bytes)
  );

  masku_alu i_alu (
    .op_i         (cur_req.op),
    .id_i         (cur_req.id),
    .vd_i         (cur_req.vd),
    .beat_idx_i   (beat_idx),
    .beat_bytes_i (beat_bytes),
    .operand_i    (operand_i),
    .result_o     (alu_result)
  );

  masku_result_queue i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (beat_fire),
    .push_data_i  (alu_result),
    .full_o       (queue_full),
    .pop_o        (pop),
    .result_req_o (result_req_o),
    .result_o     (result_o),
    .result_gnt_i (result_gnt_i)
  );

endmodule

// File: hdl/masku_alu.sv
// Combinational mask datapath, builds one beat of lane write-back payloads from the operands
`timescale 1ns/1ps

module masku_alu (
  input  masku_pkg::mask_op_e                                 op_i,
  input  masku_pkg::vid_t                                     id_i,
  input  masku_pkg::vreg_t                                    vd_i,
  // Position and size of the current beat
  input  logic [1:0]                                          beat_idx_i,
  input  logic [5:0]                                          beat_bytes_i,
  // Operand words of all lanes
  input  masku_pkg::masku_operand_t [masku_pkg::NR_LANES-1:0] operand_i,
  output masku_pkg::masku_result_t  [masku_pkg::NR_LANES-1:0] result_o
);

  import masku_pkg::*;

  elen_t  [NR_LANES-1:0]      wdata;
  logic   [NR_LANES-1:0][3:0] lane_bytes;
  strb_t  [NR_LANES-1:0]      be;
  vaddr_t                     addr;

  // Bitwise operation on every lane
  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      unique case (op_i)
        VMANDNOT: wdata[l] = ~operand_i[l].a & operand_i[l].m;
        VMAND:    wdata[l] = operand_i[l].a & operand_i[l].m;
        VMOR:     wdata[l] = operand_i[l].a | operand_i[l].m;
        VMXOR:    wdata[l] = operand_i[l].a ^ operand_i[l].m;
        VMORNOT:  wdata[l] = ~operand_i[l].a | operand_i[l].m;
        VMNAND:   wdata[l] = ~(operand_i[l].a & operand_i[l].m);
        VMNOR:    wdata[l] = ~(operand_i[l].a | operand_i[l].m);
        VMXNOR:   wdata[l] = ~(operand_i[l].a ^ operand_i[l].m);
        default:  wdata[l] = '0;
      endcase
    end
  end

  // Spread the beat bytes evenly, low lanes take the remainder
  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      lane_bytes[l] = 4'(beat_bytes_i / NR_LANES);
      if (l < (beat_bytes_i % NR_LANES)) begin
        lane_bytes[l] = lane_bytes[l] + 4'd1;
      end
    end
  end

  // Byte enable is a run of low ones
  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      for (int b = 0; b < STRB_W; b++) begin
        be[l][b] = (b < lane_bytes[l]);
      end
    end
  end

  // Same word address in every lane
  assign addr = vaddr_t'(vd_i) * vaddr_t'(WORDS_PER_VREG) + vaddr_t'(beat_idx_i);

  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      result_o[l].id    = id_i;
      result_o[l].addr  = addr;
      result_o[l].wdata = wdata[l];
      result_o[l].be    = be[l];
    end
  end

endmodule

// File: hdl/masku_ctrl_fsm.sv
// Instruction control of the mask unit, takes one request at a time and signals its completion
`timescale 1ns/1ps

module masku_ctrl_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Sequencer request
  input  masku_pkg::masku_req_t            req_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  // Progress from the counters and the datapath
  input  logic                             issue_last_i,
  input  logic                             commit_zero_i,
  input  logic                             beat_fire_i,
  // Held instruction and control to the datapath
  output masku_pkg::masku_req_t            cur_req_o,
  output logic                             load_o,
  output logic                             issuing_o,
  // One-cycle completion bit per id
  output logic [masku_pkg::NR_VINSN-1:0]   vinsn_done_o
);

  import masku_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } state_e;

  state_e                state_q, state_d;
  logic                  accept;
  logic                  finish;
  logic [NR_VINSN-1:0]   done_d;

  // Hold off new work while the done pulse is out
  assign req_ready_o = (state_q == IDLE) && !(|vinsn_done_o);
  assign accept      = req_valid_i && req_ready_o;
  assign load_o      = accept;
  assign issuing_o   = (state_q == ISSUE);
  // All results written back
  assign finish      = (state_q == DRAIN) && commit_zero_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:  if (accept) state_d = ISSUE;
      // Last beat leaves for the result queue
      ISSUE: if (beat_fire_i && issue_last_i) state_d = DRAIN;
      DRAIN: if (finish) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    done_d = '0;
    if (finish) begin
      done_d[cur_req_o.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      vinsn_done_o <= '0;
    end else begin
      state_q      <= state_d;
      vinsn_done_o <= done_d;
    end
  end

  // Request payload, captured on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_req_o <= req_i;
    end
  end

endmodule

// File: hdl/masku_elem_counter.sv
// Remaining-bit bookkeeping of the mask unit for issue and write-back, plus beat sizing
`timescale 1ns/1ps

module masku_elem_counter (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Start of an instruction
  input  logic              load_i,
  input  masku_pkg::vlen_t  vl_i,
  // One beat consumed, one queue entry written back
  input  logic              beat_fire_i,
  input  logic              pop_i,
  // Status
  output logic              issue_last_o,
  output logic              commit_zero_o,
  output logic [1:0]        beat_idx_o,
  output logic [5:0]        beat_bytes_o
);

  import masku_pkg::*;

  vlen_t      issue_rem_q;
  vlen_t      commit_rem_q;
  logic [7:0] issue_bytes;

  // Decrement by one beat, never below zero
  function automatic vlen_t sat_sub(vlen_t v);
    if (v < vlen_t'(BEAT_BITS)) begin
      return '0;
    end
    return v - vlen_t'(BEAT_BITS);
  endfunction

  // vl is a multiple of 8, so this is exact
  assign issue_bytes = 8'(issue_rem_q >> 3);

  // A full beat is 32 bytes, the tail may be shorter
  assign beat_bytes_o = (issue_bytes > 8'(BEAT_BITS / 8)) ? 6'(BEAT_BITS / 8)
                                                          : 6'(issue_bytes);

  // Current beat empties the issue count
  assign issue_last_o  = (issue_rem_q <= vlen_t'(BEAT_BITS));
  assign commit_zero_o = (commit_rem_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
      beat_idx_o   <= '0;
    end else if (load_i) begin
      issue_rem_q  <= vl_i;
      commit_rem_q <= vl_i;
      beat_idx_o   <= '0;
    end else begin
      if (beat_fire_i) begin
        issue_rem_q <= sat_sub(issue_rem_q);
        // Word offset inside the destination register
        beat_idx_o  <= beat_idx_o + 2'd1;
      end
      if (pop_i) begin
        commit_rem_q <= sat_sub(commit_rem_q);
      end
    end
  end

endmodule

// File: hdl/masku_pkg.sv
// Shared widths, operation codes and port structs of the mask unit, imported by all its modules
package masku_pkg;

  // Lane organization
  localparam int unsigned NR_LANES = 4;
  localparam int unsigned ELEN     = 64;
  localparam int unsigned STRB_W   = ELEN / 8;
  // One beat takes one word from every lane
  localparam int unsigned BEAT_BITS = NR_LANES * ELEN;

  // Register file geometry
  localparam int unsigned VLEN           = 1024;
  localparam int unsigned WORDS_PER_VREG = VLEN / BEAT_BITS;

  // Result buffering between ALU and lanes
  localparam int unsigned RESULT_QUEUE_DEPTH = 2;

  // Instruction ids tracked by the sequencer
  localparam int unsigned NR_VINSN = 8;

  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  // Holds 0 up to VLEN inclusive
  typedef logic [$clog2(VLEN):0]       vlen_t;
  typedef logic [4:0]                  vreg_t;
  // Lane-local word address, 32 registers of WORDS_PER_VREG words
  typedef logic [6:0]                  vaddr_t;
  typedef logic [ELEN-1:0]             elen_t;
  typedef logic [STRB_W-1:0]           strb_t;

  // Bitwise mask operations
  typedef enum logic [2:0] {
    VMANDNOT,
    VMAND,
    VMOR,
    VMXOR,
    VMORNOT,
    VMNAND,
    VMNOR,
    VMXNOR
  } mask_op_e;

  // Instruction from the sequencer, vl counts bits
  typedef struct packed {
    vid_t     id;
    mask_op_e op;
    vreg_t    vd;
    vlen_t    vl;
  } masku_req_t;

  // Both source words of one lane, arriving together
  typedef struct packed {
    elen_t a;
    elen_t m;
  } masku_operand_t;

  // Write-back payload for one lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } masku_result_t;

endpackage

// File: hdl/masku_result_queue.sv
// Result queue of the mask unit, holds beats until every lane has granted its write-back
`timescale 1ns/1ps

module masku_result_queue (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  // Write side, one entry per beat
  input  logic                                                push_i,
  input  masku_pkg::masku_result_t  [masku_pkg::NR_LANES-1:0] push_data_i,
  output logic                                                full_o,
  output logic                                                pop_o,
  // Per-lane request/grant toward the lanes
  output logic                      [masku_pkg::NR_LANES-1:0] result_req_o,
  output masku_pkg::masku_result_t  [masku_pkg::NR_LANES-1:0] result_o,
  input  logic                      [masku_pkg::NR_LANES-1:0] result_gnt_i
);

  import masku_pkg::*;

  // Entry payloads
  masku_result_t [RESULT_QUEUE_DEPTH-1:0][NR_LANES-1:0] data_q;
  // Lanes still waiting for a grant, per entry
  logic [RESULT_QUEUE_DEPTH-1:0][NR_LANES-1:0]          valid_q;

  logic [$clog2(RESULT_QUEUE_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(RESULT_QUEUE_DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(RESULT_QUEUE_DEPTH):0]   cnt_q;

  logic [NR_LANES-1:0] head_valid;
  logic [NR_LANES-1:0] gnt;
  logic                empty;

  assign empty  = (cnt_q == '0);
  assign full_o = (cnt_q == ($clog2(RESULT_QUEUE_DEPTH) + 1)'(RESULT_QUEUE_DEPTH));

  // Head entry goes out to the lanes
  assign head_valid   = valid_q[rd_ptr_q];
  assign result_req_o = head_valid;
  assign result_o     = data_q[rd_ptr_q];

  // Only a grant against a live request counts
  assign gnt = result_gnt_i & head_valid;

  // Last outstanding lanes granted this cycle
  assign pop_o = !empty && ((head_valid & ~gnt) == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Drop granted lanes from the head
      valid_q[rd_ptr_q] <= head_valid & ~gnt;

      // Write slot differs from the head when both happen together
      if (push_i) begin
        valid_q[wr_ptr_q] <= '1;
        if (wr_ptr_q == ($clog2(RESULT_QUEUE_DEPTH))'(RESULT_QUEUE_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end

      if (pop_o) begin
        if (rd_ptr_q == ($clog2(RESULT_QUEUE_DEPTH))'(RESULT_QUEUE_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end

      // Occupancy
      if (push_i && !pop_o) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && pop_o) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// File: masku.f
hdl/masku_pkg.sv
hdl/masku_ctrl_fsm.sv
hdl/masku_elem_counter.sv
hdl/masku_alu.sv
hdl/masku_result_queue.sv
hdl/masku.sv
testbench/masku_assertions.sv
testbench/tb_masku.sv

// File: testbench/masku_assertions.sv
// Protocol assertions on the mask unit top level, bound into masku by the testbench
`timescale 1ns/1ps

module masku_assertions (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           req_ready_o,
  input logic [masku_pkg::NR_LANES-1:0] operand_ready_o,
  input logic [masku_pkg::NR_LANES-1:0] result_req_o,
  input logic [masku_pkg::NR_LANES-1:0] result_gnt_i,
  input logic [masku_pkg::NR_VINSN-1:0] vinsn_done_o
);

  // Failed assertions so far, read back by the testbench
  int unsigned fail_cnt = 0;

  // A lane request stays up until that lane is granted
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o & ~result_gnt_i) != '0 |=>
      ($past(result_req_o & ~result_gnt_i) & ~result_req_o) == '0)
    else begin
      fail_cnt++;
      $error("result_req_o dropped without a grant");
    end

  // Never two instructions done at once
  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(vinsn_done_o))
    else begin
      fail_cnt++;
      $error("more than one vinsn_done_o bit high");
    end

  // Operands only flow while an instruction is held
  ready_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_ready_o && (operand_ready_o != '0)))
    else begin
      fail_cnt++;
      $error("operand_ready_o high while idle");
    end

  // Done lasts one cycle
  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vinsn_done_o != '0 |=> vinsn_done_o == '0)
    else begin
      fail_cnt++;
      $error("vinsn_done_o held longer than one cycle");
    end

endmodule

// File: testbench/tb_masku.sv
// Mask unit testbench that runs an instruction table against lane models and checks write-back
`timescale 1ns/1ps

module tb_masku;

  import masku_pkg::*;

  // One table row with the grant chance in percent
  typedef struct packed {
    mask_op_e   op;
    vreg_t      vd;
    vlen_t      vl;
    vid_t       id;
    logic [6:0] gnt_pct;
  } row_t;

  typedef masku_result_t [NR_LANES-1:0] beat_t;

  localparam int NUM_ROWS    = 15;
  localparam int ROW_TIMEOUT = 4000;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  masku_req_t                    req;
  logic                          req_valid;
  logic                          req_ready;
  masku_operand_t [NR_LANES-1:0] operand;
  logic [NR_LANES-1:0]           operand_valid;
  logic [NR_LANES-1:0]           operand_ready;
  logic [NR_LANES-1:0]           result_req;
  beat_t                         result;
  logic [NR_LANES-1:0]           result_gnt;
  logic [NR_VINSN-1:0]           vinsn_done;

  row_t                rows [NUM_ROWS];
  // Beats in flight and their still ungranted lanes
  beat_t               exp_q [$];
  logic [NR_LANES-1:0] pend_q [$];
  int unsigned         err_cnt;
  int unsigned         rows_ok;
  int unsigned         rows_bad;
  int unsigned         full_cycles;
  int                  cur_row;
  logic                aborted;

  always #2 clk_i = ~clk_i;

  masku uut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_req_o    (result_req),
    .result_o        (result),
    .result_gnt_i    (result_gnt),
    .vinsn_done_o    (vinsn_done)
  );

  bind masku masku_assertions i_masku_assertions (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_ready_o     (req_ready_o),
    .operand_ready_o (operand_ready_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_o    (vinsn_done_o)
  );

  task automatic report_mismatch(input string sig, input logic [63:0] got, input logic [63:0] exp);
    err_cnt++;
    $display("[FAIL] row %0d %s got %0h expected %0h", cur_row, sig, got, exp);
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("row %0d error: %s", cur_row, what);
  endtask

  // Mask operations as defined on A and M
  function automatic elen_t ref_op(mask_op_e op, elen_t a, elen_t m);
    case (op)
      VMANDNOT: return m & ~a;
      VMAND:    return a & m;
      VMOR:     return a | m;
      VMXOR:    return a ^ m;
      VMORNOT:  return m | ~a;
      VMNAND:   return ~(a & m);
      VMNOR:    return ~(a | m);
      default:  return ~(a ^ m);
    endcase
  endfunction

  // Expected write-back of beat k
  function automatic beat_t expect_beat(row_t r, int k, masku_operand_t [NR_LANES-1:0] opd);
    beat_t b;
    int    bytes;
    int    nb;
    // Up to 32 bytes per beat
    bytes = (int'(r.vl) - k * 256) / 8;
    if (bytes > 32) begin
      bytes = 32;
    end
    for (int l = 0; l < NR_LANES; l++) begin
      // Remainder bytes go to the low lanes
      nb = bytes / 4 + ((l < bytes % 4) ? 1 : 0);
      b[l].id    = r.id;
      b[l].addr  = vaddr_t'(int'(r.vd) * 4 + k);
      b[l].wdata = ref_op(r.op, opd[l].a, opd[l].m);
      b[l].be    = strb_t'((1 << nb) - 1);
    end
    return b;
  endfunction

  task automatic new_operands();
    for (int l = 0; l < NR_LANES; l++) begin
      operand[l].a = {$urandom, $urandom};
      operand[l].m = {$urandom, $urandom};
    end
  endtask

  task automatic check_reset();
    cur_row = -1;
    if (req_ready !== 1'b1) report_mismatch("req_ready_o", req_ready, 1);
    if (operand_ready !== '0) report_mismatch("operand_ready_o", operand_ready, 0);
    if (result_req !== '0) report_mismatch("result_req_o", result_req, 0);
    if (vinsn_done !== '0) report_mismatch("vinsn_done_o", vinsn_done, 0);
    $display("reset: %s", (err_cnt == 0) ? "ok" : "FAIL");
  endtask

  task automatic run_row(input int n);
    row_t                r;
    beat_t               head;
    logic [NR_LANES-1:0] exp_req;
    logic [NR_LANES-1:0] eff;
    logic [NR_VINSN-1:0] exp_done;
    logic                full;
    logic                advance;
    logic                got_done;
    int                  nbeats;
    int                  sent;
    int                  cycles;
    int                  pop_cycle;
    int unsigned         errs_before;
    r           = rows[n];
    cur_row     = n;
    errs_before = err_cnt;
    nbeats      = (int'(r.vl) + 255) / 256;
    exp_done    = NR_VINSN'(1) << r.id;
    sent        = 0;
    pop_cycle   = 0;
    advance     = 1'b0;
    got_done    = 1'b0;
    exp_q.delete();
    pend_q.delete();
    cycles = 0;
    while (req_ready !== 1'b1) begin
      if (cycles == 50) begin
        report_error("timeout waiting for req_ready_o");
        aborted = 1'b1;
        return;
      end
      @(negedge clk_i);
      cycles++;
    end
    req.id        = r.id;
    req.op        = r.op;
    req.vd        = r.vd;
    req.vl        = r.vl;
    req_valid     = 1'b1;
    new_operands();
    operand_valid = '1;
    #1;
    // Nothing consumed before the accept edge
    if (operand_ready !== '0) report_error("operand_ready_o high in the accept cycle");
    cycles = 0;
    while (!got_done) begin
      @(negedge clk_i);
      req_valid = 1'b0;
      cycles++;
      if (cycles > ROW_TIMEOUT) begin
        report_error("timeout waiting for vinsn_done_o");
        aborted = 1'b1;
        return;
      end
      if (advance) begin
        new_operands();
        advance = 1'b0;
      end
      if (vinsn_done !== '0) begin
        got_done = 1'b1;
        if (vinsn_done !== exp_done) report_mismatch("vinsn_done_o", vinsn_done, exp_done);
        if (sent != nbeats || exp_q.size() != 0) begin
          report_error("done before all results were written back");
        end else if (cycles != pop_cycle + 2) begin
          report_error("done bit not one cycle after the last pop");
        end
      end
      // Requests show the ungranted lanes of the oldest beat
      exp_req = (exp_q.size() > 0) ? pend_q[0] : '0;
      if (result_req !== exp_req) report_mismatch("result_req_o", result_req, exp_req);
      for (int l = 0; l < NR_LANES; l++) begin
        result_gnt[l] = (($urandom % 100) < r.gnt_pct);
      end
      eff = result_gnt & exp_req;
      if (exp_q.size() > 0) begin
        head = exp_q[0];
      end
      for (int l = 0; l < NR_LANES; l++) begin
        if (eff[l]) begin
          if (result[l].id !== head[l].id)
            report_mismatch($sformatf("result_o[%0d].id", l), result[l].id, head[l].id);
          if (result[l].addr !== head[l].addr)
            report_mismatch($sformatf("result_o[%0d].addr", l), result[l].addr, head[l].addr);
          if (result[l].wdata !== head[l].wdata)
            report_mismatch($sformatf("result_o[%0d].wdata", l), result[l].wdata, head[l].wdata);
          if (result[l].be !== head[l].be)
            report_mismatch($sformatf("result_o[%0d].be", l), result[l].be, head[l].be);
        end
      end
      full = (exp_q.size() == RESULT_QUEUE_DEPTH);
      if (full) begin
        full_cycles++;
      end
      // Lanes offer the beat and one lane sometimes lags
      operand_valid = (sent < nbeats) ? '1 : '0;
      if (($urandom % 8) == 0) begin
        operand_valid[$urandom % NR_LANES] = 1'b0;
      end
      #1;
      if (full && operand_ready !== '0) report_error("operand_ready_o high with two beats held");
      if (operand_valid !== '1 && operand_ready !== '0)
        report_error("operand_ready_o high with a lane not valid");
      if (operand_ready === '1) begin
        exp_q.push_back(expect_beat(r, sent, operand));
        pend_q.push_back('1);
        sent++;
        advance = 1'b1;
      end
      // Granted lanes leave the oldest beat and it pops once none is left
      if (eff != '0) begin
        pend_q[0] = pend_q[0] & ~eff;
        if (pend_q[0] == '0) begin
          void'(exp_q.pop_front());
          void'(pend_q.pop_front());
          pop_cycle = cycles;
        end
      end
    end
    @(negedge clk_i);
    result_gnt    = '0;
    operand_valid = '0;
    if (req_ready !== 1'b1) report_error("req_ready_o low in the cycle after the done bit");
    if (err_cnt == errs_before) begin
      rows_ok++;
    end else begin
      rows_bad++;
    end
    $display("row %0d op %0d vd %0d vl %0d id %0d: %s", n, r.op, r.vd, r.vl, r.id,
             (err_cnt == errs_before) ? "ok" : "FAIL");
  endtask

  initial begin
    void'($urandom(32'h9ea4_72ff));
    rst_ni        = 1'b0;
    req           = '0;
    req_valid     = 1'b0;
    operand       = '0;
    operand_valid = '0;
    result_gnt    = '0;
    err_cnt       = 0;
    rows_ok       = 0;
    rows_bad      = 0;
    full_cycles   = 0;
    aborted       = 1'b0;
    // op, vd, vl, id, grant percent
    rows[0]  = '{VMANDNOT, 5'd1,  11'd256,  3'd0, 7'd100};
    rows[1]  = '{VMAND,    5'd2,  11'd256,  3'd1, 7'd100};
    rows[2]  = '{VMOR,     5'd3,  11'd256,  3'd2, 7'd100};
    rows[3]  = '{VMXOR,    5'd4,  11'd256,  3'd3, 7'd100};
    rows[4]  = '{VMORNOT,  5'd5,  11'd256,  3'd4, 7'd100};
    rows[5]  = '{VMNAND,   5'd6,  11'd256,  3'd5, 7'd100};
    rows[6]  = '{VMNOR,    5'd7,  11'd256,  3'd6, 7'd100};
    rows[7]  = '{VMXNOR,   5'd31, 11'd256,  3'd7, 7'd100};
    // Short tails
    rows[8]  = '{VMAND,    5'd8,  11'd40,   3'd2, 7'd100};
    rows[9]  = '{VMOR,     5'd9,  11'd8,    3'd5, 7'd100};
    // Full register followed by heavy back-pressure
    rows[10] = '{VMXOR,    5'd10, 11'd1024, 3'd3, 7'd100};
    rows[11] = '{VMXNOR,   5'd11, 11'd1024, 3'd6, 7'd30};
    rows[12] = '{VMANDNOT, 5'd12, 11'd768,  3'd1, 7'd20};
    rows[13] = '{VMNAND,   5'd13, 11'd296,  3'd4, 7'd50};
    rows[14] = '{VMORNOT,  5'd0,  11'd1000, 3'd7, 7'd40};
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_reset();
    for (int n = 0; n < NUM_ROWS && !aborted; n++) begin
      run_row(n);
    end
    // Back-pressure rows must have held two beats at some point
    if (!aborted && full_cycles == 0) begin
      err_cnt++;
      $display("result queue never held two beats under back-pressure");
    end
    $display("rows passed %0d, rows failed %0d, errors %0d, assertion failures %0d, full cycles %0d",
             rows_ok, rows_bad, err_cnt, uut.i_masku_assertions.fail_cnt, full_cycles);
    if (err_cnt == 0 && !aborted && uut.i_masku_assertions.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
